// ==== hw/mem_ctrl_pkg.sv ====
package mem_ctrl_pkg;

    // ##################################################
    // widths
    // ##################################################

    typedef logic [31:0] addr_t;      // byte address on the ram port.
    typedef logic [31:0] word_t;      // instruction or data word.
    typedef logic [7:0]  byte_t;      // one ram data byte.
    typedef logic [1:0]  byte_idx_t;  // byte position within a word.

    // ##################################################
    // requesters and access kinds
    // ##################################################

    typedef enum logic [1:0] {
        OWN_FETCH,
        OWN_LOAD,
        OWN_STORE
    } owner_t;

    typedef enum logic [2:0] {
        LD_B,
        LD_H,
        LD_W,
        LD_BU,
        LD_HU
    } load_kind_t;

    typedef enum logic [1:0] {
        ST_B,
        ST_H,
        ST_W
    } store_size_t;

    // setup carries the first byte, drain waits for the last read byte.
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SETUP,
        SEQ_XFER,
        SEQ_DRAIN
    } seq_state_t;

endpackage

// ==== hw/mem_arbiter.sv ====
module mem_arbiter (
    input  logic                 clk_in,
    input  logic                 rst_in,
    input  logic                 rdy_in,
    input  logic                 flush,
    input  logic                 fetch_req,
    input  logic                 load_req,
    input  logic                 store_req,
    input  logic                 xfer_end,
    output mem_ctrl_pkg::owner_t owner,
    output logic                 busy,
    output logic                 fetch_grant,
    output logic                 load_grant,
    output logic                 store_grant
);

    mem_ctrl_pkg::owner_t winner;
    logic                 any_req;

    assign any_req = fetch_req | load_req | store_req;

    // the scan starts at the last owner and rotates fetch, load, store.
    always_comb begin
        winner = owner;
        case (owner)
            mem_ctrl_pkg::OWN_LOAD: begin
                if (load_req)       winner = mem_ctrl_pkg::OWN_LOAD;
                else if (store_req) winner = mem_ctrl_pkg::OWN_STORE;
                else if (fetch_req) winner = mem_ctrl_pkg::OWN_FETCH;
            end
            mem_ctrl_pkg::OWN_STORE: begin
                if (store_req)      winner = mem_ctrl_pkg::OWN_STORE;
                else if (fetch_req) winner = mem_ctrl_pkg::OWN_FETCH;
                else if (load_req)  winner = mem_ctrl_pkg::OWN_LOAD;
            end
            default: begin
                if (fetch_req)      winner = mem_ctrl_pkg::OWN_FETCH;
                else if (load_req)  winner = mem_ctrl_pkg::OWN_LOAD;
                else if (store_req) winner = mem_ctrl_pkg::OWN_STORE;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            owner <= mem_ctrl_pkg::OWN_FETCH;
            busy  <= 1'b0;
        end else if (rdy_in) begin
            if (flush) begin
                owner <= mem_ctrl_pkg::OWN_FETCH;  // fetch restarts after a flush.
                busy  <= 1'b0;
            end else if (busy) begin
                if (xfer_end) busy <= 1'b0;
            end else if (any_req) begin
                owner <= winner;
                busy  <= 1'b1;
            end
        end
    end

    assign fetch_grant = (owner == mem_ctrl_pkg::OWN_FETCH);
    assign load_grant  = (owner == mem_ctrl_pkg::OWN_LOAD);
    assign store_grant = (owner == mem_ctrl_pkg::OWN_STORE);

endmodule

// ==== hw/byte_sequencer.sv ====
module byte_sequencer (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      rdy_in,
    input  logic                      flush,
    input  logic                      busy,
    input  mem_ctrl_pkg::owner_t      owner,
    input  mem_ctrl_pkg::addr_t       fetch_pc,
    input  mem_ctrl_pkg::addr_t       load_addr,
    input  mem_ctrl_pkg::addr_t       store_addr,
    input  mem_ctrl_pkg::word_t       store_data,
    input  mem_ctrl_pkg::load_kind_t  load_kind,
    input  mem_ctrl_pkg::store_size_t store_size,
    output mem_ctrl_pkg::addr_t       ram_addr,
    output mem_ctrl_pkg::byte_t       ram_wdata,
    output logic                      ram_wr,
    output logic                      xfer_end,
    output logic                      capture,
    output mem_ctrl_pkg::byte_idx_t   cap_idx,
    output logic                      cap_last,
    output logic                      fetch_done,
    output logic                      load_done,
    output logic                      store_done
);

    mem_ctrl_pkg::seq_state_t state;
    mem_ctrl_pkg::byte_idx_t  last_idx;   // index of the final byte of this transfer.
    mem_ctrl_pkg::byte_idx_t  bus_idx;    // byte whose address is on the ram port.
    mem_ctrl_pkg::byte_idx_t  issue_idx;
    mem_ctrl_pkg::byte_idx_t  xfer_last;
    mem_ctrl_pkg::addr_t      base_addr;
    logic                     is_store;
    logic                     more;
    logic                     issue;
    logic                     rd_v;       // a read address is on the ram port.

    // ##################################################
    // access length and base address of the owner
    // ##################################################

    always_comb begin
        base_addr = fetch_pc;
        xfer_last = 2'd3;
        case (owner)
            mem_ctrl_pkg::OWN_LOAD: begin
                base_addr = load_addr;
                case (load_kind)
                    mem_ctrl_pkg::LD_B, mem_ctrl_pkg::LD_BU: xfer_last = 2'd0;
                    mem_ctrl_pkg::LD_H, mem_ctrl_pkg::LD_HU: xfer_last = 2'd1;
                    default:                                 xfer_last = 2'd3;
                endcase
            end
            mem_ctrl_pkg::OWN_STORE: begin
                base_addr = store_addr;
                case (store_size)
                    mem_ctrl_pkg::ST_B: xfer_last = 2'd0;
                    mem_ctrl_pkg::ST_H: xfer_last = 2'd1;
                    default:            xfer_last = 2'd3;
                endcase
            end
            default: begin
                base_addr = fetch_pc;
                xfer_last = 2'd3;
            end
        endcase
    end

    assign is_store  = (owner == mem_ctrl_pkg::OWN_STORE);
    assign more      = (bus_idx != last_idx);
    assign issue_idx = (state == mem_ctrl_pkg::SEQ_IDLE) ? 2'd0 : bus_idx + 2'd1;
    assign issue     = ((state == mem_ctrl_pkg::SEQ_IDLE) && busy) ||
                       (((state == mem_ctrl_pkg::SEQ_SETUP) ||
                         (state == mem_ctrl_pkg::SEQ_XFER)) && more);

    // ##################################################
    // state machine and ram port
    // ##################################################

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= mem_ctrl_pkg::SEQ_IDLE;
            ram_wr     <= 1'b0;
            rd_v       <= 1'b0;
            capture    <= 1'b0;
            fetch_done <= 1'b0;
            load_done  <= 1'b0;
            store_done <= 1'b0;
        end else if (rdy_in) begin
            capture    <= rd_v;     // read data arrives one cycle after the address.
            cap_idx    <= bus_idx;
            fetch_done <= 1'b0;
            load_done  <= 1'b0;
            store_done <= 1'b0;
            if (flush) begin
                state   <= mem_ctrl_pkg::SEQ_IDLE;
                ram_wr  <= 1'b0;
                rd_v    <= 1'b0;
                capture <= 1'b0;
            end else begin
                case (state)
                    mem_ctrl_pkg::SEQ_IDLE: begin
                        if (busy) begin
                            last_idx <= xfer_last;
                            state    <= mem_ctrl_pkg::SEQ_SETUP;
                        end
                    end
                    mem_ctrl_pkg::SEQ_SETUP, mem_ctrl_pkg::SEQ_XFER: begin
                        if (more) begin
                            state <= mem_ctrl_pkg::SEQ_XFER;
                        end else begin
                            state  <= mem_ctrl_pkg::SEQ_DRAIN;
                            ram_wr <= 1'b0;  // the last write byte lands on this edge.
                            rd_v   <= 1'b0;
                        end
                    end
                    mem_ctrl_pkg::SEQ_DRAIN: begin
                        state      <= mem_ctrl_pkg::SEQ_IDLE;
                        fetch_done <= (owner == mem_ctrl_pkg::OWN_FETCH);
                        load_done  <= (owner == mem_ctrl_pkg::OWN_LOAD);
                        store_done <= (owner == mem_ctrl_pkg::OWN_STORE);
                    end
                    default: state <= mem_ctrl_pkg::SEQ_IDLE;
                endcase
                if (issue) begin
                    ram_addr  <= base_addr + mem_ctrl_pkg::addr_t'(issue_idx);
                    ram_wdata <= store_data[8*issue_idx +: 8];
                    ram_wr    <= is_store;
                    rd_v      <= !is_store;
                    bus_idx   <= issue_idx;
                end
            end
        end
    end

    assign xfer_end = (state == mem_ctrl_pkg::SEQ_DRAIN);
    assign cap_last = capture && (cap_idx == last_idx);

endmodule

// ==== hw/load_assembler.sv ====
module load_assembler (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     rdy_in,
    input  logic                     flush,
    input  logic                     capture,
    input  mem_ctrl_pkg::byte_idx_t  cap_idx,
    input  logic                     cap_last,
    input  mem_ctrl_pkg::byte_t      ram_rdata,
    input  mem_ctrl_pkg::load_kind_t load_kind,
    output mem_ctrl_pkg::word_t      fetch_inst,
    output mem_ctrl_pkg::word_t      load_data
);

    mem_ctrl_pkg::word_t partial;
    mem_ctrl_pkg::word_t full_word;  // partial word with the arriving byte merged in.

    function automatic mem_ctrl_pkg::word_t extend(
        input mem_ctrl_pkg::word_t      w,
        input mem_ctrl_pkg::load_kind_t kind
    );
        mem_ctrl_pkg::word_t r;
        case (kind)
            mem_ctrl_pkg::LD_B:  r = {{24{w[7]}}, w[7:0]};
            mem_ctrl_pkg::LD_H:  r = {{16{w[15]}}, w[15:0]};
            mem_ctrl_pkg::LD_BU: r = {24'd0, w[7:0]};
            mem_ctrl_pkg::LD_HU: r = {16'd0, w[15:0]};
            default:             r = w;
        endcase
        return r;
    endfunction

    always_comb begin
        full_word                   = partial;
        full_word[8*cap_idx +: 8]   = ram_rdata;
    end

    // ##################################################
    // byte collection and result registers
    // ##################################################

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            partial <= '0;
        end else if (rdy_in) begin
            if (flush) begin
                partial <= '0;
            end else if (capture) begin
                partial <= full_word;
            end
        end
    end

    // results hold until the next completed read.
    always_ff @(posedge clk_in) begin
        if (rdy_in && !flush && cap_last) begin
            fetch_inst <= full_word;
            load_data  <= extend(full_word, load_kind);
        end
    end

endmodule

// ==== hw/mem_ctrl.sv ====
module mem_ctrl (
    input  logic                      clk_in,
    input  logic                      rst_in,
    input  logic                      rdy_in,
    input  logic                      flush,
    output mem_ctrl_pkg::addr_t       ram_addr,
    output mem_ctrl_pkg::byte_t       ram_wdata,
    output logic                      ram_wr,
    input  mem_ctrl_pkg::byte_t       ram_rdata,
    input  logic                      fetch_req,
    input  mem_ctrl_pkg::addr_t       fetch_pc,
    output logic                      fetch_grant,
    output logic                      fetch_done,
    output mem_ctrl_pkg::word_t       fetch_inst,
    input  logic                      load_req,
    input  mem_ctrl_pkg::addr_t       load_addr,
    input  mem_ctrl_pkg::load_kind_t  load_kind,
    output logic                      load_grant,
    output logic                      load_done,
    output mem_ctrl_pkg::word_t       load_data,
    input  logic                      store_req,
    input  mem_ctrl_pkg::addr_t       store_addr,
    input  mem_ctrl_pkg::word_t       store_data,
    input  mem_ctrl_pkg::store_size_t store_size,
    output logic                      store_grant,
    output logic                      store_done
);

    mem_ctrl_pkg::owner_t    owner;
    logic                    busy;
    logic                    xfer_end;   // last cycle of the running transfer.
    logic                    capture;
    mem_ctrl_pkg::byte_idx_t cap_idx;
    logic                    cap_last;

    mem_arbiter arb0 (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rdy_in      (rdy_in),
        .flush       (flush),
        .fetch_req   (fetch_req),
        .load_req    (load_req),
        .store_req   (store_req),
        .xfer_end    (xfer_end),
        .owner       (owner),
        .busy        (busy),
        .fetch_grant (fetch_grant),
        .load_grant  (load_grant),
        .store_grant (store_grant)
    );

    byte_sequencer seq0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_in     (rdy_in),
        .flush      (flush),
        .busy       (busy),
        .owner      (owner),
        .fetch_pc   (fetch_pc),
        .load_addr  (load_addr),
        .store_addr (store_addr),
        .store_data (store_data),
        .load_kind  (load_kind),
        .store_size (store_size),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_wr     (ram_wr),
        .xfer_end   (xfer_end),
        .capture    (capture),
        .cap_idx    (cap_idx),
        .cap_last   (cap_last),
        .fetch_done (fetch_done),
        .load_done  (load_done),
        .store_done (store_done)
    );

    load_assembler asm0 (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .rdy_in     (rdy_in),
        .flush      (flush),
        .capture    (capture),
        .cap_idx    (cap_idx),
        .cap_last   (cap_last),
        .ram_rdata  (ram_rdata),
        .load_kind  (load_kind),
        .fetch_inst (fetch_inst),
        .load_data  (load_data)
    );

endmodule

// ==== tb/mem_ctrl_assertions.sv ====
module mem_ctrl_assertions (
    input logic                      clk_in,
    input logic                      rst_in,
    input logic                      rdy_in,
    input logic                      busy,
    input mem_ctrl_pkg::owner_t      owner,
    input mem_ctrl_pkg::load_kind_t  load_kind,
    input mem_ctrl_pkg::store_size_t store_size,
    input logic                      ram_wr,
    input logic                      fetch_done,
    input logic                      load_done,
    input logic                      store_done,
    input logic                      fetch_grant,
    input logic                      load_grant,
    input logic                      store_grant
);

    logic [3:0] edge_cnt;   // rdy edges since the accepting edge.
    logic [3:0] len_q;
    logic [3:0] len_now;
    logic       busy_d;

    always_comb begin
        len_now = 4'd4;
        if (owner == mem_ctrl_pkg::OWN_LOAD) begin
            if (load_kind == mem_ctrl_pkg::LD_B || load_kind == mem_ctrl_pkg::LD_BU) len_now = 4'd1;
            else if (load_kind != mem_ctrl_pkg::LD_W) len_now = 4'd2;
        end else if (owner == mem_ctrl_pkg::OWN_STORE) begin
            if (store_size == mem_ctrl_pkg::ST_B) len_now = 4'd1;
            else if (store_size == mem_ctrl_pkg::ST_H) len_now = 4'd2;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            edge_cnt <= 4'd0;
            len_q    <= 4'd0;
            busy_d   <= 1'b0;
        end else if (rdy_in) begin
            busy_d <= busy;
            if (busy && !busy_d) len_q <= len_now;    // requests are stable once granted.
            if (!busy) edge_cnt <= 4'd0;
            if (busy) edge_cnt <= edge_cnt + 4'd1;
        end
    end

    a_wr_in_busy: assert property (@(posedge clk_in) disable iff (rst_in) ram_wr |-> busy)
        else $error("ram write outside a transfer");

    a_one_done: assert property (@(posedge clk_in) disable iff (rst_in)
        $onehot0({fetch_done, load_done, store_done}))
        else $error("more than one done pulse");

    a_one_grant: assert property (@(posedge clk_in) disable iff (rst_in)
        $onehot({fetch_grant, load_grant, store_grant}))
        else $error("grant is not one-hot");

    a_done_len: assert property (@(posedge clk_in) disable iff (rst_in)
        (fetch_done || load_done || store_done) |-> (edge_cnt == len_q + 4'd2))
        else $error("done pulse latency wrong");

endmodule

bind mem_ctrl mem_ctrl_assertions asrt0 (.*);

// ==== tb/mem_ctrl_tb.sv ====
module mem_ctrl_tb;

    localparam int N_ENTRIES = 20;
    localparam int DONE_LIMIT = 40;    // cycles allowed for any single transfer.

    logic        clk_in;
    logic        rst_in;
    logic        rdy_in;
    logic        flush;
    logic [31:0] ram_addr;
    logic [7:0]  ram_wdata;
    logic        ram_wr;
    logic [7:0]  ram_rdata;
    logic        fetch_req;
    logic [31:0] fetch_pc;
    logic        fetch_grant;
    logic        fetch_done;
    logic [31:0] fetch_inst;
    logic        load_req;
    logic [31:0] load_addr;
    logic [2:0]  load_kind;
    logic        load_grant;
    logic        load_done;
    logic [31:0] load_data;
    logic        store_req;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic [1:0]  store_size;
    logic        store_grant;
    logic        store_done;

    logic [7:0]  ram_mem [0:65535];
    logic [7:0]  shadow [0:65535];
    integer      seed;
    int          errors;
    int          checks;
    logic [1:0]  last_owner;           // 0 fetch, 1 load, 2 store.

    // stimulus table. mask bit 0 is fetch, bit 1 load, bit 2 store.
    logic [2:0]  t_mask [N_ENTRIES];
    logic [15:0] t_addr [N_ENTRIES];
    logic [2:0]  t_kind [N_ENTRIES];
    logic [31:0] t_data [N_ENTRIES];
    int          t_flush [N_ENTRIES];
    int          t_stall [N_ENTRIES];

    mem_ctrl dut0 (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rdy_in      (rdy_in),
        .flush       (flush),
        .ram_addr    (ram_addr),
        .ram_wdata   (ram_wdata),
        .ram_wr      (ram_wr),
        .ram_rdata   (ram_rdata),
        .fetch_req   (fetch_req),
        .fetch_pc    (fetch_pc),
        .fetch_grant (fetch_grant),
        .fetch_done  (fetch_done),
        .fetch_inst  (fetch_inst),
        .load_req    (load_req),
        .load_addr   (load_addr),
        .load_kind   (mem_ctrl_pkg::load_kind_t'(load_kind)),
        .load_grant  (load_grant),
        .load_done   (load_done),
        .load_data   (load_data),
        .store_req   (store_req),
        .store_addr  (store_addr),
        .store_data  (store_data),
        .store_size  (mem_ctrl_pkg::store_size_t'(store_size)),
        .store_grant (store_grant),
        .store_done  (store_done)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    // the ram stalls with the rest of the core.
    always @(posedge clk_in) begin
        if (rdy_in) begin
            if (ram_wr) ram_mem[ram_addr[15:0]] <= ram_wdata;
            ram_rdata <= ram_mem[ram_addr[15:0]];
        end
    end

    // ##################################################
    // reference model
    // ##################################################

    function automatic logic [1:0] pick_winner(input logic [1:0] last, input logic [2:0] mask);
        logic [1:0] cand;
        for (int k = 0; k < 3; k++) begin
            cand = 2'((int'(last) + k) % 3);
            if (mask[cand]) return cand;
        end
        return last;
    endfunction

    function automatic int access_len(input logic [1:0] who, input logic [2:0] kind);
        if (who == 2'd0) return 4;
        if (who == 2'd1) return (kind == 3'd0 || kind == 3'd3) ? 1 : (kind == 3'd2) ? 4 : 2;
        return (kind[1:0] == 2'd0) ? 1 : (kind[1:0] == 2'd1) ? 2 : 4;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [15:0] a);
        return {shadow[16'(a + 3)], shadow[16'(a + 2)], shadow[16'(a + 1)], shadow[a]};
    endfunction

    function automatic logic [31:0] expect_load(input logic [15:0] a, input logic [2:0] kind);
        logic [31:0] w;
        w = shadow_word(a);
        case (kind)
            3'd0:    return {{24{w[7]}}, w[7:0]};     // lb sign extends.
            3'd1:    return {{16{w[15]}}, w[15:0]};
            3'd3:    return {24'd0, w[7:0]};
            3'd4:    return {16'd0, w[15:0]};
            default: return w;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic add_entry(input int i, input logic [2:0] mask, input logic [15:0] addr,
                             input logic [2:0] kind, input logic [31:0] data,
                             input int flush_after, input int stall);
        t_mask[i]  = mask;
        t_addr[i]  = addr;
        t_kind[i]  = kind;
        t_data[i]  = data;
        t_flush[i] = flush_after;
        t_stall[i] = stall;
    endtask

    // ##################################################
    // entry execution
    // ##################################################

    task automatic run_entry(input int i);
        logic [1:0] winner;
        logic [2:0] done_vec;
        logic       rdy_prev;
        logic       found;
        logic       flushed;
        int         n;
        int         cnt;
        int         waited;
        int         stall_left;
        int         limit;
        int         err_before;
        err_before = errors;
        winner     = pick_winner(last_owner, t_mask[i]);
        n          = access_len(winner, t_kind[i]);
        stall_left = t_stall[i];
        limit      = (t_flush[i] > 0) ? 12 : DONE_LIMIT;
        fetch_pc   = 32'(t_addr[i]);
        load_addr  = 32'(t_addr[i]);
        store_addr = 32'(t_addr[i]);
        load_kind  = t_kind[i];
        store_size = t_kind[i][1:0];
        store_data = t_data[i];
        fetch_req  = t_mask[i][0];
        load_req   = t_mask[i][1];
        store_req  = t_mask[i][2];
        cnt        = 0;
        waited     = 0;
        found      = 1'b0;
        flushed    = 1'b0;
        done_vec   = 3'b000;
        while (!found && waited < limit) begin
            rdy_prev = rdy_in;
            @(negedge clk_in);
            waited++;
            if (rdy_prev) cnt++;                       // only edges with rdy_in high count.
            done_vec = {store_done, load_done, fetch_done};
            if (done_vec != 3'b000) found = 1'b1;
            flush = (t_flush[i] > 0 && cnt == t_flush[i] && !flushed);
            if (flush) begin
                flushed   = 1'b1;
                fetch_req = 1'b0;                      // a flushed request is withdrawn.
                load_req  = 1'b0;
                store_req = 1'b0;
            end
            rdy_in = !(stall_left > 0 && cnt >= 2);
            if (!rdy_in) stall_left--;
        end
        fetch_req = 1'b0;
        load_req  = 1'b0;
        store_req = 1'b0;
        flush     = 1'b0;
        rdy_in    = 1'b1;
        if (t_flush[i] > 0) begin
            check_value("done_after_flush", 32'(found), 32'd0);
            check_value("fetch_grant", 32'(fetch_grant), 32'd1);
            last_owner = 2'd0;
        end else if (!found) begin
            errors++;
            $display("timeout: no done pulse for entry %0d after %0d cycles", i, waited);
        end else begin
            check_value("done", 32'(done_vec), 32'(3'b001 << winner));
            check_value("done_latency", 32'(cnt - 1), 32'(n + 2));  // cnt has the accepting edge.
            check_value("grant", 32'({store_grant, load_grant, fetch_grant}),
                        32'(3'b001 << winner));
            if (winner == 2'd0) begin
                check_value("fetch_inst", fetch_inst, shadow_word(t_addr[i]));
            end else if (winner == 2'd1) begin
                check_value("load_data", load_data, expect_load(t_addr[i], t_kind[i]));
            end else begin
                for (int k = 0; k < n; k++) shadow[16'(t_addr[i] + k)] = t_data[i][8*k +: 8];
                for (int j = -1; j < 5; j++) begin
                    check_value("ram_byte", 32'(ram_mem[16'(int'(t_addr[i]) + j)]),
                                32'(shadow[16'(int'(t_addr[i]) + j)]));
                end
            end
            last_owner = winner;
        end
        $display("entry %0d mask %b addr %h: %s", i, t_mask[i], t_addr[i],
                 (errors == err_before) ? "ok" : "FAILED");
        @(negedge clk_in);
    endtask

    initial begin
        seed        = 32'h3ae;
        errors      = 0;
        checks      = 0;
        last_owner  = 2'd0;
        rst_in      = 1'b1;
        rdy_in      = 1'b1;
        flush       = 1'b0;
        ram_rdata   = 8'h00;
        fetch_req   = 1'b0;
        fetch_pc    = 32'h0;
        load_req    = 1'b0;
        load_addr   = 32'h0;
        load_kind   = 3'd2;
        store_req   = 1'b0;
        store_addr  = 32'h0;
        store_data  = 32'h0;
        store_size  = 2'd2;
        for (int a = 0; a < 65536; a++) begin
            ram_mem[a] = 8'($random(seed));
            shadow[a]  = ram_mem[a];
        end
        add_entry(0,  3'b001, 16'h0100, 3'd2, 32'h0,         0, 0);
        add_entry(1,  3'b010, 16'h0104, 3'd2, 32'h0,         0, 0);
        add_entry(2,  3'b100, 16'h0200, 3'd2, 32'h80f1_8283, 0, 0);
        add_entry(3,  3'b010, 16'h0200, 3'd0, 32'h0,         0, 0);
        add_entry(4,  3'b010, 16'h0200, 3'd3, 32'h0,         0, 0);
        add_entry(5,  3'b010, 16'h0202, 3'd1, 32'h0,         0, 0);
        add_entry(6,  3'b010, 16'h0202, 3'd4, 32'h0,         0, 0);
        add_entry(7,  3'b010, 16'h0200, 3'd2, 32'h0,         0, 0);
        add_entry(8,  3'b100, 16'h0300, 3'd0, 32'h0000_005a, 0, 0);
        add_entry(9,  3'b100, 16'h0305, 3'd1, 32'h0000_1234, 0, 0);
        add_entry(10, 3'b001, 16'h0300, 3'd2, 32'h0,         0, 0);
        add_entry(11, 3'b010, 16'h0305, 3'd1, 32'h0,         0, 0);
        add_entry(12, 3'b111, 16'h0400, 3'd2, 32'hdead_beef, 0, 0);   // owner is load here.
        add_entry(13, 3'b101, 16'h0404, 3'd2, 32'hcafe_f00d, 0, 0);
        add_entry(14, 3'b011, 16'h0404, 3'd2, 32'h0,         0, 0);
        add_entry(15, 3'b110, 16'h0408, 3'd2, 32'h1357_9bdf, 0, 0);
        add_entry(16, 3'b010, 16'h0500, 3'd2, 32'h0,         2, 0);
        add_entry(17, 3'b010, 16'h0500, 3'd2, 32'h0,         0, 0);
        add_entry(18, 3'b001, 16'h0208, 3'd2, 32'h0,         0, 3);
        add_entry(19, 3'b010, 16'h0203, 3'd0, 32'h0,         0, 2);
        repeat (16) @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);
        for (int i = 0; i < N_ENTRIES; i++) run_entry(i);
        $display("%0d entries, %0d checks, %0d errors", N_ENTRIES, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
hw/mem_ctrl_pkg.sv
hw/mem_arbiter.sv
hw/byte_sequencer.sv
hw/load_assembler.sv
hw/mem_ctrl.sv
tb/mem_ctrl_assertions.sv
tb/mem_ctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_ctrl_tb
RTL_TOP   ?= mem_ctrl
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^ALL CHECKS PASSED$$"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) \
		hw/mem_ctrl_pkg.sv hw/mem_arbiter.sv hw/byte_sequencer.sv \
		hw/load_assembler.sv hw/mem_ctrl.sv

clean:
	rm -rf $(OBJ_DIR)
